/* list.f */
+incdir+test
logic/fetch_pkg.sv
logic/fetch_flush_fsm.sv
logic/fetch_req_counter.sv
logic/fetch_addr_gen.sv
logic/fetch_resp_fifo.sv
logic/insn_unpacker.sv
logic/axil_fetch.sv
test/fetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the fetch unit testbench with Verilator and run it.
# The exit status of the simulation is the result of the run.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fetch_tb \
	-f list.f \
	-o fetch_sim

./obj_dir/fetch_sim

/* test/fetch_tb_model.svh */
// Reference model helpers for the fetch unit testbench
// Instruction value rule, slave bus encoding, SLVERR address window
// and compare tasks for the DUT output types

`ifndef FETCH_TB_MODEL_SVH
`define FETCH_TB_MODEL_SVH

// Bus words from ERR_LO up to ERR_HI answer with SLVERR
localparam logic [ADDR_W-1:0] ERR_LO = 32'h0000_5020;
localparam logic [ADDR_W-1:0] ERR_HI = 32'h0000_5040;

function automatic logic [INSN_W-1:0] insn_at(input logic [ADDR_W-1:0] addr);
	return addr + 32'h1357_0000;
endfunction

function automatic bit in_err_window(input logic [ADDR_W-1:0] addr);
	logic [ADDR_W-1:0] word_addr;
	word_addr = {addr[ADDR_W-1:3], 3'b000};
	return (word_addr >= ERR_LO) && (word_addr < ERR_HI);
endfunction

// Lower lane holds the lower address, each lane byte-reversed on the bus
function automatic logic [BUS_DW-1:0] bus_word_at(input logic [ADDR_W-1:0] addr);
	logic [BUS_DW-1:0] data;
	logic [INSN_W-1:0] insn;
	int                lane;
	for (lane = 0; lane < 2; lane++)
	begin
		insn = insn_at({addr[ADDR_W-1:3], 3'b000} + 32'(lane * 4));
		data[lane*32 +: 32] = {insn[7:0], insn[15:8], insn[23:16], insn[31:24]};
	end
	return data;
endfunction

task automatic check_insn(input insn_out_t got, input insn_out_t want, input string name);
	if (got !== want)
	begin
		$display("FAILED at time %0t: %s expected insn=%h pc=%h illegal=%b, got insn=%h pc=%h illegal=%b",
			$time, name, want.insn, want.pc, want.illegal, got.insn, got.pc, got.illegal);
		stop_run();
	end
endtask

task automatic check_valid(input bit got, input bit want, input string name);
	if (got !== want)
	begin
		$display("FAILED at time %0t: %s expected %b, got %b", $time, name, want, got);
		stop_run();
	end
endtask

`endif

/* test/fetch_tb.sv */
// Testbench for the AXI-lite instruction fetch unit
// Clock and reset, stimulus sequence, AXI-lite slave model with random
// ready and latency, output checker against the instruction rule, timeout

`timescale 1ns/1ps

module fetch_tb
	import fetch_pkg::*;
();

	localparam int FETCH_LIMIT = 8;
	localparam bit SWAP_ENDIAN = 1'b1;
	localparam int PLANNED_INSNS = 150;
	localparam int MAX_CYCLES = 200 * PLANNED_INSNS;

	logic              S_AXI_ACLK;
	logic              fifo_reset;
	logic              i_new_pc;
	logic [ADDR_W-1:0] i_pc;
	logic              i_clear_cache;
	logic              i_ready;
	insn_out_t         o_insn_out;
	logic              o_valid;
	logic              o_m_axi_arvalid;
	logic              i_m_axi_arready;
	logic [ADDR_W-1:0] o_m_axi_araddr;
	logic              i_m_axi_rvalid;
	logic              o_m_axi_rready;
	logic [BUS_DW-1:0] i_m_axi_rdata;
	logic [1:0]        i_m_axi_rresp;

	// Stimulus knobs, changed on clock edges
	int                ready_pct;
	logic              ar_hold;
	// Slave state
	logic [ADDR_W-1:0] ar_q [$];
	logic [ADDR_W-1:0] r_addr;
	int                r_wait;
	// Checker state
	logic [ADDR_W-1:0] exp_pc;
	logic              active;
	logic              stuck;
	logic              flush_seen;
	logic              held;
	logic              ar_allow;
	insn_out_t         held_out;
	insn_out_t         want;
	int                handoffs;
	int                cycles = 0;

	task automatic stop_run();
		$display("Testbench failed");
		$fatal(1);
	endtask

	`include "fetch_tb_model.svh"

	axil_fetch #(
		.FETCH_LIMIT (FETCH_LIMIT),
		.SWAP_ENDIAN (SWAP_ENDIAN)
	) axil_fetch_i (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.fifo_reset      (fifo_reset),
		.i_new_pc        (i_new_pc),
		.i_pc            (i_pc),
		.i_clear_cache   (i_clear_cache),
		.i_ready         (i_ready),
		.o_insn_out      (o_insn_out),
		.o_valid         (o_valid),
		.o_m_axi_arvalid (o_m_axi_arvalid),
		.i_m_axi_arready (i_m_axi_arready),
		.o_m_axi_araddr  (o_m_axi_araddr),
		.i_m_axi_rvalid  (i_m_axi_rvalid),
		.o_m_axi_rready  (o_m_axi_rready),
		.i_m_axi_rdata   (i_m_axi_rdata),
		.i_m_axi_rresp   (i_m_axi_rresp)
	);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #4 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	//////////////////////////////////////////////////
	// AXI slave and CPU ready
	//////////////////////////////////////////////////

	always @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			i_m_axi_arready <= 1'b0;
			i_m_axi_rvalid <= 1'b0;
			i_ready <= 1'b0;
			ar_q.delete();
			r_wait = 0;
		end
		else
		begin
			i_ready <= ($urandom % 100) < ready_pct;
			if (o_m_axi_arvalid && i_m_axi_arready)
				ar_q.push_back(o_m_axi_araddr);
			if (ar_hold)
				i_m_axi_arready <= 1'b0;
			else
				i_m_axi_arready <= ($urandom % 4) != 0;
			if (r_wait > 0)
			begin
				r_wait = r_wait - 1;
				i_m_axi_rvalid <= 1'b0;
			end
			else if (ar_q.size() != 0)
			begin
				r_addr = ar_q.pop_front();
				i_m_axi_rvalid <= 1'b1;
				i_m_axi_rdata <= bus_word_at(r_addr);
				i_m_axi_rresp <= in_err_window(r_addr) ? 2'b10 : 2'b00;
				r_wait = $urandom % 3;
			end
			else
				i_m_axi_rvalid <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Output checker
	//////////////////////////////////////////////////

	always @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			exp_pc = '0;
			active = 1'b0;
			flush_seen = 1'b0;
			held = 1'b0;
			ar_allow = 1'b0;
			stuck <= 1'b0;
			handoffs <= 0;
		end
		else
		begin
			// R beats are always accepted
			check_valid(o_m_axi_rready, 1'b1, "o_m_axi_rready");
			if (flush_seen)
				check_valid(o_valid, 1'b0, "o_valid after flush");
			if (stuck)
				check_valid(o_valid, 1'b1, "o_valid while illegal");
			if (!active)
				check_valid(o_valid, 1'b0, "o_valid with no stream");
			if (held)
			begin
				check_valid(o_valid, 1'b1, "o_valid under back-pressure");
				check_insn(o_insn_out, held_out, "o_insn_out under back-pressure");
			end
			if (o_valid)
			begin
				want.insn = insn_at(exp_pc);
				want.pc = exp_pc;
				want.illegal = in_err_window(exp_pc);
				check_insn(o_insn_out, want, "o_insn_out");
				// Illegal output is never consumed, so the PC stays put
				if (want.illegal)
					stuck <= 1'b1;
				else if (i_ready)
				begin
					exp_pc = exp_pc + 4;
					handoffs <= handoffs + 1;
				end
			end
			held = o_valid && !i_ready;
			held_out = o_insn_out;

			// Only a request already stalled at the clear may still complete
			if (!active && o_m_axi_arvalid && i_m_axi_arready)
			begin
				if (!ar_allow)
				begin
					$display("AR handshake at time %0t with no stream started", $time);
					stop_run();
				end
				ar_allow = 1'b0;
			end

			flush_seen = i_new_pc || i_clear_cache;
			if (i_new_pc)
			begin
				exp_pc = i_pc;
				active = 1'b1;
				held = 1'b0;
				stuck <= 1'b0;
			end
			if (i_clear_cache)
			begin
				active = 1'b0;
				held = 1'b0;
				ar_allow = o_m_axi_arvalid && !i_m_axi_arready;
				stuck <= 1'b0;
			end
		end
	end

	always @(posedge S_AXI_ACLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			stop_run();
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic start_stream(input logic [ADDR_W-1:0] pc);
		i_new_pc <= 1'b1;
		i_pc <= pc;
		@(posedge S_AXI_ACLK);
		i_new_pc <= 1'b0;
	endtask

	task automatic wait_insns(input int n);
		int target;
		target = handoffs + n;
		while (handoffs < target)
			@(posedge S_AXI_ACLK);
	endtask

	initial
	begin
		void'($urandom(32'hc88a));
		fifo_reset = 1'b1;
		i_new_pc = 1'b0;
		i_pc = '0;
		i_clear_cache = 1'b0;
		i_ready = 1'b0;
		i_m_axi_arready = 1'b0;
		i_m_axi_rvalid = 1'b0;
		i_m_axi_rdata = '0;
		i_m_axi_rresp = 2'b00;
		ready_pct = 70;
		ar_hold = 1'b0;
		repeat (16) @(posedge S_AXI_ACLK);
		fifo_reset <= 1'b0;
		check_valid(o_m_axi_arvalid, 1'b0, "o_m_axi_arvalid after reset");
		check_valid(o_valid, 1'b0, "o_valid after reset");
		check_valid(o_insn_out.illegal, 1'b0, "o_insn_out.illegal after reset");

		// Aligned sequential fetch
		start_stream(32'h0000_1000);
		wait_insns(40);
		// CPU holds off with an instruction waiting
		ready_pct <= 0;
		while (!o_valid)
			@(posedge S_AXI_ACLK);
		repeat (20) @(posedge S_AXI_ACLK);
		ready_pct <= 70;
		wait_insns(10);

		// Start in the upper half of a bus word
		start_stream(32'h0000_2004);
		wait_insns(20);

		// Redirect with a read just accepted
		while (!(o_m_axi_arvalid && i_m_axi_arready))
			@(posedge S_AXI_ACLK);
		start_stream(32'h0000_3104);
		wait_insns(20);

		// Redirect while the AR request is stalled
		wait_insns(5);
		ar_hold <= 1'b1;
		@(posedge S_AXI_ACLK);
		while (!(o_m_axi_arvalid && !i_m_axi_arready))
			@(posedge S_AXI_ACLK);
		start_stream(32'h0000_4008);
		repeat (3) @(posedge S_AXI_ACLK);
		ar_hold <= 1'b0;
		wait_insns(20);

		// Stream runs into the SLVERR window
		start_stream(32'h0000_5000);
		while (!stuck)
			@(posedge S_AXI_ACLK);
		repeat (30) @(posedge S_AXI_ACLK);
		start_stream(32'h0000_6000);
		wait_insns(10);

		// Cache clear, then a quiet stretch
		wait_insns(5);
		i_clear_cache <= 1'b1;
		@(posedge S_AXI_ACLK);
		i_clear_cache <= 1'b0;
		repeat (40) @(posedge S_AXI_ACLK);
		start_stream(32'h0000_7000);
		wait_insns(10);

		$display("Testbench passed");
		$finish;
	end

endmodule

/* logic/axil_fetch.sv */
// AXI-lite instruction fetch unit, top level
// Flush FSM, request counter, AR address generator, response FIFO
// and instruction unpacker, wired together

`timescale 1ns/1ps

module axil_fetch
	import fetch_pkg::*;
#(
	parameter int FETCH_LIMIT = 8,
	parameter bit SWAP_ENDIAN = 1'b1
) (
	input  logic              S_AXI_ACLK,
	input  logic              fifo_reset,
	// CPU side
	input  logic              i_new_pc,
	input  logic [ADDR_W-1:0] i_pc,
	input  logic              i_clear_cache,
	input  logic              i_ready,
	output insn_out_t         o_insn_out,
	output logic              o_valid,
	// AXI-lite read channels
	output logic              o_m_axi_arvalid,
	input  logic              i_m_axi_arready,
	output logic [ADDR_W-1:0] o_m_axi_araddr,
	input  logic              i_m_axi_rvalid,
	output logic              o_m_axi_rready,
	input  logic [BUS_DW-1:0] i_m_axi_rdata,
	input  logic [1:0]        i_m_axi_rresp
);

	fetch_ctl_t ctl;
	r_beat_t    beat;
	logic       ar_fire;
	logic       ar_stalled;
	logic       can_issue;
	logic       flush_done;
	logic       fifo_empty;
	logic       pop;
	logic       out_busy;

	assign ar_fire = o_m_axi_arvalid && i_m_axi_arready;
	// Request limit keeps the FIFO from filling, so R is always accepted
	assign o_m_axi_rready = 1'b1;

	fetch_flush_fsm fsm_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.fifo_reset    (fifo_reset),
		.i_new_pc      (i_new_pc),
		.i_clear_cache (i_clear_cache),
		.i_ar_stalled  (ar_stalled),
		.i_flush_done  (flush_done),
		.o_ctl         (ctl)
	);

	fetch_req_counter #(
		.FETCH_LIMIT (FETCH_LIMIT)
	) counter_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.fifo_reset   (fifo_reset),
		.i_ctl        (ctl),
		.i_ar_fire    (ar_fire),
		.i_r_fire     (i_m_axi_rvalid),
		.i_pop        (pop),
		.i_out_busy   (out_busy),
		.o_can_issue  (can_issue),
		.o_flush_done (flush_done)
	);

	fetch_addr_gen addr_gen_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.fifo_reset   (fifo_reset),
		.i_ctl        (ctl),
		.i_pc         (i_pc),
		.i_can_issue  (can_issue),
		.i_arready    (i_m_axi_arready),
		.o_arvalid    (o_m_axi_arvalid),
		.o_araddr     (o_m_axi_araddr),
		.o_ar_stalled (ar_stalled)
	);

	fetch_resp_fifo #(
		.FETCH_LIMIT (FETCH_LIMIT),
		.SWAP_ENDIAN (SWAP_ENDIAN)
	) fifo_i (
		.S_AXI_ACLK (S_AXI_ACLK),
		.fifo_reset (fifo_reset),
		.i_ctl      (ctl),
		.i_rvalid   (i_m_axi_rvalid),
		.i_rdata    (i_m_axi_rdata),
		.i_rresp    (i_m_axi_rresp),
		.i_pop      (pop),
		.o_beat     (beat),
		.o_empty    (fifo_empty)
	);

	insn_unpacker unpacker_i (
		.S_AXI_ACLK (S_AXI_ACLK),
		.fifo_reset (fifo_reset),
		.i_ctl      (ctl),
		.i_pc       (i_pc),
		.i_beat     (beat),
		.i_empty    (fifo_empty),
		.i_ready    (i_ready),
		.o_pop      (pop),
		.o_busy     (out_busy),
		.o_insn_out (o_insn_out),
		.o_valid    (o_valid)
	);

endmodule

/* logic/insn_unpacker.sv */
// Instruction unpacker for the fetch unit
// Pops bus words from the response FIFO and hands them to the CPU one
// 32-bit instruction at a time, with the PC of each instruction.
// A bus error makes the output illegal until the next flush

`timescale 1ns/1ps

module insn_unpacker
	import fetch_pkg::*;
(
	input  logic              S_AXI_ACLK,
	input  logic              fifo_reset,
	input  fetch_ctl_t        i_ctl,
	input  logic [ADDR_W-1:0] i_pc,
	input  r_beat_t           i_beat,
	input  logic              i_empty,
	input  logic              i_ready,
	output logic              o_pop,
	output logic              o_busy,
	output insn_out_t         o_insn_out,
	output logic              o_valid
);

	localparam int SLOT_W = $clog2(INSNS_PER_WORD + 1);
	localparam int OFS_W = WORD_LSB - 2;

	// Unconsumed instructions left in the held word
	logic [SLOT_W-1:0] slots;
	logic [BUS_DW-1:0] word;
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] pc_next;
	logic [OFS_W-1:0]  ofs;
	logic              illegal;
	logic              handoff;
	logic              last_out;
	logic              need_word;

	//////////////////////////////////////////////////
	// Handoff and pop decision
	//////////////////////////////////////////////////

	always_comb
	begin
		// An illegal output is never consumed
		handoff = o_valid && i_ready && !illegal;
		last_out = handoff && (slots == SLOT_W'(1));

		pc_next = pc;
		if (handoff)
			pc_next = {pc[ADDR_W-1:2] + 1'b1, 2'b00};

		// Instruction slot inside the word the next pop will hold
		ofs = pc_next[WORD_LSB-1:2];

		need_word = (slots == '0) || last_out;
		o_pop = need_word && !i_empty && !illegal && !i_ctl.flush;
		o_busy = o_pop || (o_valid && !last_out);
	end

	assign o_valid = (slots != '0);

	always_comb
	begin
		o_insn_out.insn = word[INSN_W-1:0];
		o_insn_out.pc = pc;
		o_insn_out.illegal = illegal;
	end

	//////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_ctl.flush)
		begin
			slots <= '0;
			illegal <= 1'b0;
		end
		else if (o_pop)
		begin
			// Start in the upper half skips the lower instruction
			slots <= SLOT_W'(INSNS_PER_WORD) - SLOT_W'(ofs);
			illegal <= i_beat.err;
		end
		else if (handoff)
			slots <= slots - 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_pop)
			word <= i_beat.data >> (INSN_W * ofs);
		else if (handoff)
			word <= word >> INSN_W;
	end

	// pc follows the instruction on the output, not the bus
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_ctl.flush)
			pc <= i_pc;
		else if (handoff)
			pc <= pc_next;
	end

endmodule

/* logic/fetch_resp_fifo.sv */
// Response FIFO for the fetch unit
// Stores R channel beats with their error bit, byte-swapping each
// 32-bit lane on entry when SWAP_ENDIAN is set. Emptied on a flush

`timescale 1ns/1ps

module fetch_resp_fifo
	import fetch_pkg::*;
#(
	parameter int FETCH_LIMIT = 8,
	parameter bit SWAP_ENDIAN = 1'b1
) (
	input  logic              S_AXI_ACLK,
	input  logic              fifo_reset,
	input  fetch_ctl_t        i_ctl,
	input  logic              i_rvalid,
	input  logic [BUS_DW-1:0] i_rdata,
	input  logic [1:0]        i_rresp,
	input  logic              i_pop,
	output r_beat_t           o_beat,
	output logic              o_empty
);

	localparam int PTR_W = (FETCH_LIMIT > 1) ? $clog2(FETCH_LIMIT) : 1;
	localparam int CNT_W = $clog2(FETCH_LIMIT + 1);
	localparam int LANES = BUS_DW / INSN_W;

	r_beat_t          mem [FETCH_LIMIT];
	r_beat_t          wr_beat;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             wr_en;
	logic             rd_en;
	logic             full;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FETCH_LIMIT - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Incoming beat, byte order fixed up per 32-bit lane
	always_comb
	begin
		wr_beat.err = i_rresp[1];
		for (int l = 0; l < LANES; l++)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (SWAP_ENDIAN)
					wr_beat.data[l*INSN_W + b*8 +: 8] = i_rdata[l*INSN_W + (3-b)*8 +: 8];
				else
					wr_beat.data[l*INSN_W + b*8 +: 8] = i_rdata[l*INSN_W + b*8 +: 8];
			end
		end
	end

	assign wr_en = i_rvalid && !i_ctl.discard;
	assign rd_en = i_pop && !o_empty;
	assign full = (count == CNT_W'(FETCH_LIMIT));
	assign o_empty = (count == '0);
	assign o_beat = mem[rd_ptr];

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (wr_en)
			mem[wr_ptr] <= wr_beat;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_ctl.flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= ptr_inc(wr_ptr);
			if (rd_en)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
		end
	end

	// The request limit upstream is what keeps RREADY safe to tie high
	no_overflow: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		(wr_en && !i_ctl.flush) |-> !full)
		else $error("fetch_resp_fifo: write while full");

endmodule

/* logic/fetch_addr_gen.sv */
// AR channel register for the fetch unit
// Loads a new PC once the AR slot is free, then steps one bus word
// per accepted request with the low address bits cleared

`timescale 1ns/1ps

module fetch_addr_gen
	import fetch_pkg::*;
(
	input  logic              S_AXI_ACLK,
	input  logic              fifo_reset,
	input  fetch_ctl_t        i_ctl,
	input  logic [ADDR_W-1:0] i_pc,
	input  logic              i_can_issue,
	input  logic              i_arready,
	output logic              o_arvalid,
	output logic [ADDR_W-1:0] o_araddr,
	output logic              o_ar_stalled
);

	logic              slot_free;
	// New PC captured while an old request still holds the slot
	logic [ADDR_W-1:0] pend_pc;
	logic [ADDR_W-1:0] start_pc;

	assign slot_free = !o_arvalid || i_arready;
	assign o_ar_stalled = !slot_free;

	always_comb
	begin
		start_pc = i_ctl.flush ? i_pc : pend_pc;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_ctl.flush)
			pend_pc <= i_pc;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			o_arvalid <= 1'b0;
		else if (slot_free)
			o_arvalid <= (i_ctl.load_pc || i_ctl.issue_en) && i_can_issue;
	end

	// Address only moves when the slot is free, so it holds through a stall
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (slot_free)
		begin
			if (i_ctl.load_pc)
				o_araddr <= {start_pc[ADDR_W-1:WORD_LSB], {WORD_LSB{1'b0}}};
			else if (o_arvalid)
				o_araddr <= {o_araddr[ADDR_W-1:WORD_LSB] + 1'b1, {WORD_LSB{1'b0}}};
		end
	end

	ar_hold: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		o_ar_stalled |=> (o_arvalid && $stable(o_araddr)))
		else $error("fetch_addr_gen: AR request changed while stalled");

endmodule

/* logic/fetch_req_counter.sv */
// Request bookkeeping for the fetch unit
// Outstanding AXI reads, words requested but not yet popped,
// and old responses still to be discarded after a flush

`timescale 1ns/1ps

module fetch_req_counter
	import fetch_pkg::*;
#(
	parameter int FETCH_LIMIT = 8
) (
	input  logic       S_AXI_ACLK,
	input  logic       fifo_reset,
	input  fetch_ctl_t i_ctl,
	input  logic       i_ar_fire,
	input  logic       i_r_fire,
	input  logic       i_pop,
	input  logic       i_out_busy,
	output logic       o_can_issue,
	output logic       o_flush_done
);

	localparam int OUT_W = $clog2(FETCH_LIMIT) + 4;
	localparam int FILL_W = $clog2(FETCH_LIMIT) + 2;
	// Leaves room for the one request that may still be sitting on AR
	localparam logic [OUT_W-1:0] BUS_MAX = {OUT_W{1'b1}} - 1'b1;

	logic [OUT_W-1:0]  out_cnt;
	logic [OUT_W-1:0]  out_next;
	logic [OUT_W-1:0]  discard_cnt;
	logic [OUT_W-1:0]  discard_next;
	logic [FILL_W-1:0] fill;
	logic [FILL_W-1:0] fill_next;
	logic [FILL_W-1:0] ahead;
	logic              stale_fire;
	logic              new_fire;
	logic              drop_r;

	always_comb
	begin
		// A handshake outside an issuing stream, or on the cycle that loads
		// a new address, carries an old request
		stale_fire = i_ar_fire && (!i_ctl.issue_en || i_ctl.load_pc);
		new_fire = i_ar_fire && !stale_fire;
		drop_r = i_r_fire && (discard_cnt != '0);
		out_next = out_cnt + OUT_W'(i_ar_fire) - OUT_W'(i_r_fire);

		// On a flush every read still owed is old
		if (i_ctl.flush)
			discard_next = out_next;
		else
			discard_next = discard_cnt + OUT_W'(stale_fire) - OUT_W'(drop_r);

		if (i_ctl.flush)
			fill_next = '0;
		else
			fill_next = fill + FILL_W'(new_fire) - FILL_W'(i_pop);

		ahead = fill_next + FILL_W'(i_out_busy && !i_ctl.flush);
		o_can_issue = (ahead < FILL_W'(FETCH_LIMIT)) && (out_next < BUS_MAX);
		o_flush_done = (discard_next == '0);
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			out_cnt <= '0;
			discard_cnt <= '0;
			fill <= '0;
		end
		else
		begin
			out_cnt <= out_next;
			discard_cnt <= discard_next;
			fill <= fill_next;
		end
	end

	// Every R beat must match an earlier AR handshake
	out_no_underflow: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		i_r_fire |-> (out_cnt != '0))
		else $error("fetch_req_counter: R beat with no read outstanding");

endmodule

/* logic/fetch_flush_fsm.sv */
// Fetch stream FSM
// IDLE, RUN and FLUSH modes, plus a new PC held back behind a stalled
// AR request. Drives the stream control struct to the rest of the unit

`timescale 1ns/1ps

module fetch_flush_fsm
	import fetch_pkg::*;
(
	input  logic       S_AXI_ACLK,
	input  logic       fifo_reset,
	input  logic       i_new_pc,
	input  logic       i_clear_cache,
	input  logic       i_ar_stalled,
	input  logic       i_flush_done,
	output fetch_ctl_t o_ctl
);

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		FLUSH
	} state_t;

	state_t state;
	// New PC waiting for the AR slot to free up
	logic   pending;

	//////////////////////////////////////////////////
	// Control outputs
	//////////////////////////////////////////////////

	always_comb
	begin
		o_ctl.flush = i_new_pc || i_clear_cache;
		// The new address may only go out once the old request has left
		o_ctl.load_pc = (i_new_pc || pending) && !i_ar_stalled && !i_clear_cache;
		o_ctl.issue_en = (state != IDLE) && !pending && !o_ctl.flush;
		// Anything that arrives outside RUN belongs to an old stream
		o_ctl.discard = (state != RUN);
	end

	//////////////////////////////////////////////////
	// State register
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_clear_cache)
		begin
			state <= IDLE;
			pending <= 1'b0;
		end
		else if (i_new_pc)
		begin
			pending <= i_ar_stalled;
			if (i_ar_stalled || !i_flush_done)
				state <= FLUSH;
			else
				state <= RUN;
		end
		else if (pending)
		begin
			// Stalled request just left, its response is still owed
			if (!i_ar_stalled)
			begin
				pending <= 1'b0;
				state <= i_flush_done ? RUN : FLUSH;
			end
		end
		else if (state == FLUSH && i_flush_done)
			state <= RUN;
	end

	// No request may start while the unit waits for a new PC
	idle_no_issue: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		(state == IDLE && !i_new_pc) |-> !(o_ctl.issue_en || o_ctl.load_pc))
		else $error("fetch_flush_fsm: request allowed in IDLE");

endmodule

/* logic/fetch_pkg.sv */
// Shared definitions for the AXI-lite instruction fetch unit
// Bus, address and instruction widths
// Returned bus beat, CPU instruction output and fetch control structs

package fetch_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	// Byte address width
	localparam int ADDR_W = 32;
	// AXI read data width
	localparam int BUS_DW = 64;
	localparam int INSN_W = 32;
	localparam int INSNS_PER_WORD = BUS_DW / INSN_W;
	// Address bits that select a byte inside one bus word
	localparam int WORD_LSB = $clog2(BUS_DW / 8);

	//////////////////////////////////////////////////
	// Structs
	//////////////////////////////////////////////////

	// One R channel beat as stored in the response FIFO
	typedef struct packed {
		logic              err;
		logic [BUS_DW-1:0] data;
	} r_beat_t;

	// Instruction handed to the CPU
	typedef struct packed {
		logic [INSN_W-1:0] insn;
		logic [ADDR_W-1:0] pc;
		logic              illegal;
	} insn_out_t;

	// Stream control from the flush FSM
	typedef struct packed {
		logic flush;
		logic load_pc;
		logic issue_en;
		logic discard;
	} fetch_ctl_t;

endpackage
